/* Makefile */
# Verilator build and run of the data cache testbench

SRCS := $(wildcard *.sv *.svh) sources.f
BIN  := obj_dir/Vtb_dcache

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_dcache -f sources.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

/* dcache_bus_pkg.sv */
//##########################################################
// Data cache bus types
// CPU and memory request and response structs
//##########################################################
`default_nettype none

`include "dcache_cfg.svh"

package dcache_bus_pkg;

    // CPU access kind
    typedef enum logic {
        MEM_OP_LOAD  = 1'b0,
        MEM_OP_STORE = 1'b1
    } mem_op_t;

    // CPU request, one 64-bit word with byte strobes
    typedef struct packed {
        mem_op_t                    op;
        logic [`DC_ADDR_BITS-1:0]   addr;
        logic [`DC_DATA_BITS-1:0]   wdata;
        logic [`DC_STRB_BITS-1:0]   wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic [`DC_ADDR_BITS-1:0]   addr;
        logic [`DC_DATA_BITS-1:0]   rdata;
    } cpu_resp_t;

    // Line transfer to memory, addr is line aligned
    typedef struct packed {
        logic                           write;
        logic [`DC_ADDR_BITS-1:0]       addr;
        logic [`DC_LINE_BYTES*8-1:0]    data;
    } mem_req_t;

endpackage

`default_nettype wire

/* dcache_cfg.svh */
//##########################################################
// Data cache geometry
// Address, data, line and set sizes shared by all blocks
//##########################################################
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// CPU port
`define DC_ADDR_BITS 32
`define DC_DATA_BITS 64
`define DC_STRB_BITS 8

// Cache line, 256 bits
`define DC_LINE_BYTES 32
`define DC_LINE_OFFS_BITS 5

// Sets and ways
`define DC_SETS 16
`define DC_INDEX_BITS 4

// One LRU bit per set only covers two ways
`define DC_WAYS 2

// Address bits above index and offset
`define DC_TAG_BITS 23

`endif

/* dcache_ctrl.sv */
//##########################################################
// Data cache controller
// Lookup, write-back, refill with store merge, reset sweep
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl (
    input  wire logic                           i_clk,
    input  wire logic                           i_nrst,
    input  wire logic                           i_req_valid,
    input  wire dcache_bus_pkg::cpu_req_t       i_req,
    output logic                                o_req_ready,
    output logic                                o_resp_valid,
    output dcache_bus_pkg::cpu_resp_t           o_resp,
    input  wire logic                           i_resp_ready,
    output logic                                o_mem_valid,
    output dcache_bus_pkg::mem_req_t            o_mem_req,
    input  wire logic                           i_mem_ready,
    input  wire logic                           i_mem_data_valid,
    input  wire logic [`DC_LINE_BYTES*8-1:0]    i_mem_data,
    output logic [`DC_INDEX_BITS-1:0]           o_index,
    output dcache_line_pkg::way_wr_t            o_way_wr,
    output logic [`DC_WAYS-1:0]                 o_way_we,
    output logic                                o_lru_touch,
    output logic [$clog2(`DC_WAYS)-1:0]         o_lru_way,
    input  wire logic                           i_hit,
    input  wire logic [$clog2(`DC_WAYS)-1:0]    i_hit_way,
    input  wire logic [`DC_LINE_BYTES*8-1:0]    i_rd_line,
    input  wire logic [$clog2(`DC_WAYS)-1:0]    i_victim_way,
    input  wire logic [`DC_TAG_BITS-1:0]        i_victim_tag,
    input  wire dcache_line_pkg::tag_flags_t    i_victim_flags
);

    localparam int LINE_BITS     = `DC_LINE_BYTES * 8;
    localparam int WORD_LSB      = $clog2(`DC_STRB_BITS);
    localparam int WORD_SEL_BITS = $clog2(`DC_LINE_BYTES / `DC_STRB_BITS);

    dcache_line_pkg::dc_state_t         state;
    logic [`DC_INDEX_BITS-1:0]          sweep_cnt;
    logic                               mem_valid_q;
    logic [$clog2(`DC_WAYS)-1:0]        vict_way_q;
    dcache_bus_pkg::cpu_req_t           req_q;
    dcache_bus_pkg::mem_req_t           mem_req_q;
    logic [LINE_BITS-1:0]               fill_line_q;

    logic [`DC_INDEX_BITS-1:0]          req_index;
    logic [`DC_TAG_BITS-1:0]            req_tag;
    logic [`DC_ADDR_BITS-1:0]           req_line_addr;
    logic [WORD_SEL_BITS-1:0]           word_sel;
    logic                               is_store;
    logic                               wb_needed;
    logic                               resp_done;
    logic [`DC_LINE_BYTES-1:0]          line_strb;
    logic [LINE_BITS-1:0]               base_line;
    logic [LINE_BITS-1:0]               merged_line;

    assign req_index     = req_q.addr[`DC_LINE_OFFS_BITS +: `DC_INDEX_BITS];
    assign req_tag       = req_q.addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
    assign req_line_addr = {req_q.addr[`DC_ADDR_BITS-1:`DC_LINE_OFFS_BITS],
                            {`DC_LINE_OFFS_BITS{1'b0}}};
    assign word_sel      = req_q.addr[WORD_LSB +: WORD_SEL_BITS];
    assign is_store      = (req_q.op == dcache_bus_pkg::MEM_OP_STORE);
    assign wb_needed     = i_victim_flags.valid && i_victim_flags.dirty;

    // Store bytes placed over the way line or the refilled line
    always_comb begin
        line_strb = '0;
        if (is_store) begin
            line_strb[word_sel*`DC_STRB_BITS +: `DC_STRB_BITS] = req_q.wstrb;
        end
        base_line = (state == dcache_line_pkg::S_FILL) ? fill_line_q : i_rd_line;
        for (int b = 0; b < `DC_LINE_BYTES; b++) begin
            merged_line[b*8 +: 8] = line_strb[b] ? req_q.wdata[(b % `DC_STRB_BITS)*8 +: 8]
                                                 : base_line[b*8 +: 8];
        end
    end

    always_comb begin
        o_req_ready  = (state == dcache_line_pkg::S_IDLE);
        o_resp_valid = ((state == dcache_line_pkg::S_CHECK_HIT) && i_hit) ||
                       (state == dcache_line_pkg::S_FILL);
        o_resp.addr  = req_q.addr;
        o_resp.rdata = merged_line[word_sel*`DC_DATA_BITS +: `DC_DATA_BITS];
        resp_done    = o_resp_valid && i_resp_ready;
        o_mem_valid  = mem_valid_q;
        o_mem_req    = mem_req_q;
        o_lru_touch  = resp_done;
        o_lru_way    = (state == dcache_line_pkg::S_FILL) ? vict_way_q : i_hit_way;

        // Index of the new request while idle, else the held one
        case (state)
            dcache_line_pkg::S_RESET: o_index = sweep_cnt;
            dcache_line_pkg::S_IDLE:  o_index = i_req.addr[`DC_LINE_OFFS_BITS +: `DC_INDEX_BITS];
            default:                  o_index = req_index;
        endcase

        o_way_wr.index       = req_index;
        o_way_wr.tag         = req_tag;
        o_way_wr.data        = merged_line;
        o_way_wr.strb        = line_strb;
        o_way_wr.flags.valid = 1'b1;
        o_way_wr.flags.dirty = is_store;
        o_way_wr.we          = 1'b0;
        o_way_we             = '0;
        case (state)
            dcache_line_pkg::S_RESET: begin
                // Invalidate one set per cycle in all ways
                o_way_wr.index = sweep_cnt;
                o_way_wr.strb  = '0;
                o_way_wr.flags = '0;
                o_way_wr.we    = 1'b1;
                o_way_we       = '1;
            end
            dcache_line_pkg::S_CHECK_HIT: begin
                o_way_wr.we         = resp_done && is_store;
                o_way_we[i_hit_way] = 1'b1;
            end
            dcache_line_pkg::S_FILL: begin
                o_way_wr.strb        = '1;
                o_way_wr.we          = resp_done;
                o_way_we[vict_way_q] = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= dcache_line_pkg::S_RESET;
            sweep_cnt   <= '0;
            mem_valid_q <= 1'b0;
            vict_way_q  <= '0;
        end else begin
            case (state)
                dcache_line_pkg::S_RESET: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == `DC_INDEX_BITS'(`DC_SETS - 1)) begin
                        state <= dcache_line_pkg::S_IDLE;
                    end
                end
                dcache_line_pkg::S_IDLE: begin
                    if (i_req_valid) begin
                        state <= dcache_line_pkg::S_CHECK_HIT;
                    end
                end
                dcache_line_pkg::S_CHECK_HIT: begin
                    if (i_hit) begin
                        if (i_resp_ready) begin
                            state <= dcache_line_pkg::S_IDLE;
                        end
                    end else begin
                        vict_way_q  <= i_victim_way;
                        mem_valid_q <= 1'b1;
                        state       <= wb_needed ? dcache_line_pkg::S_WB_GRANT
                                                 : dcache_line_pkg::S_RD_GRANT;
                    end
                end
                dcache_line_pkg::S_WB_GRANT: begin
                    if (i_mem_ready) begin
                        mem_valid_q <= 1'b0;
                        state       <= dcache_line_pkg::S_WB_WAIT;
                    end
                end
                dcache_line_pkg::S_WB_WAIT: begin
                    // Victim written, now fetch the requested line
                    if (i_mem_data_valid) begin
                        mem_valid_q <= 1'b1;
                        state       <= dcache_line_pkg::S_RD_GRANT;
                    end
                end
                dcache_line_pkg::S_RD_GRANT: begin
                    if (i_mem_ready) begin
                        mem_valid_q <= 1'b0;
                        state       <= dcache_line_pkg::S_RD_WAIT;
                    end
                end
                dcache_line_pkg::S_RD_WAIT: begin
                    if (i_mem_data_valid) begin
                        state <= dcache_line_pkg::S_FILL;
                    end
                end
                dcache_line_pkg::S_FILL: begin
                    if (i_resp_ready) begin
                        state <= dcache_line_pkg::S_IDLE;
                    end
                end
                default: begin
                    state <= dcache_line_pkg::S_IDLE;
                end
            endcase
        end
    end

    // Request, memory command and refill line
    always_ff @(posedge i_clk) begin
        if ((state == dcache_line_pkg::S_IDLE) && i_req_valid) begin
            req_q <= i_req;
        end
        if ((state == dcache_line_pkg::S_CHECK_HIT) && !i_hit) begin
            mem_req_q.write <= wb_needed;
            mem_req_q.addr  <= wb_needed ? {i_victim_tag, req_index, {`DC_LINE_OFFS_BITS{1'b0}}}
                                         : req_line_addr;
            mem_req_q.data  <= i_rd_line;
        end
        if ((state == dcache_line_pkg::S_WB_WAIT) && i_mem_data_valid) begin
            mem_req_q.write <= 1'b0;
            mem_req_q.addr  <= req_line_addr;
        end
        if ((state == dcache_line_pkg::S_RD_WAIT) && i_mem_data_valid) begin
            fill_line_q <= i_mem_data;
        end
    end

endmodule

`default_nettype wire

/* dcache_line_pkg.sv */
//##########################################################
// Data cache line types
// Tag entry, way read and write records, controller states
//##########################################################
`default_nettype none

`include "dcache_cfg.svh"

package dcache_line_pkg;

    typedef struct packed {
        logic valid;
        logic dirty;
    } tag_flags_t;

    // Write command, broadcast to every way
    typedef struct packed {
        logic [`DC_INDEX_BITS-1:0]      index;
        logic [`DC_TAG_BITS-1:0]        tag;
        logic [`DC_LINE_BYTES*8-1:0]    data;
        logic [`DC_LINE_BYTES-1:0]      strb;
        tag_flags_t                     flags;
        logic                           we;
    } way_wr_t;

    // Lookup result of one way
    typedef struct packed {
        logic                           hit;
        logic [`DC_TAG_BITS-1:0]        tag;
        tag_flags_t                     flags;
        logic [`DC_LINE_BYTES*8-1:0]    data;
    } way_rd_t;

    typedef enum logic [2:0] {
        S_RESET,
        S_IDLE,
        S_CHECK_HIT,
        S_WB_GRANT,
        S_WB_WAIT,
        S_RD_GRANT,
        S_RD_WAIT,
        S_FILL
    } dc_state_t;

endpackage

`default_nettype wire

/* dcache_top.sv */
//##########################################################
// Data cache top level
// Two-way write-back cache between CPU and line memory
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
    input  wire logic                           i_clk,
    input  wire logic                           i_nrst,
    input  wire logic                           i_req_valid,
    input  wire dcache_bus_pkg::cpu_req_t       i_req,
    output logic                                o_req_ready,
    output logic                                o_resp_valid,
    output dcache_bus_pkg::cpu_resp_t           o_resp,
    input  wire logic                           i_resp_ready,
    output logic                                o_mem_valid,
    output dcache_bus_pkg::mem_req_t            o_mem_req,
    input  wire logic                           i_mem_ready,
    input  wire logic                           i_mem_data_valid,
    input  wire logic [`DC_LINE_BYTES*8-1:0]    i_mem_data
);

    logic [`DC_INDEX_BITS-1:0]                  index;
    dcache_line_pkg::way_wr_t                   way_wr;
    logic [`DC_WAYS-1:0]                        way_we;
    dcache_line_pkg::way_rd_t [`DC_WAYS-1:0]    way_rd;
    logic                                       lru_touch;
    logic [$clog2(`DC_WAYS)-1:0]                lru_way;
    logic                                       hit;
    logic [$clog2(`DC_WAYS)-1:0]                hit_way;
    logic [`DC_LINE_BYTES*8-1:0]                rd_line;
    logic [$clog2(`DC_WAYS)-1:0]                victim_way;
    logic [`DC_TAG_BITS-1:0]                    victim_tag;
    dcache_line_pkg::tag_flags_t                victim_flags;

    dcache_ctrl dcache_ctrl_inst (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_req_valid      (i_req_valid),
        .i_req            (i_req),
        .o_req_ready      (o_req_ready),
        .o_resp_valid     (o_resp_valid),
        .o_resp           (o_resp),
        .i_resp_ready     (i_resp_ready),
        .o_mem_valid      (o_mem_valid),
        .o_mem_req        (o_mem_req),
        .i_mem_ready      (i_mem_ready),
        .i_mem_data_valid (i_mem_data_valid),
        .i_mem_data       (i_mem_data),
        .o_index          (index),
        .o_way_wr         (way_wr),
        .o_way_we         (way_we),
        .o_lru_touch      (lru_touch),
        .o_lru_way        (lru_way),
        .i_hit            (hit),
        .i_hit_way        (hit_way),
        .i_rd_line        (rd_line),
        .i_victim_way     (victim_way),
        .i_victim_tag     (victim_tag),
        .i_victim_flags   (victim_flags)
    );

    // Request tag rides on the write command
    for (genvar g = 0; g < `DC_WAYS; g++) begin : g_way
        dcache_way dcache_way_inst (
            .i_clk   (i_clk),
            .i_nrst  (i_nrst),
            .i_index (index),
            .i_we    (way_we[g]),
            .i_wr    (way_wr),
            .i_tag   (way_wr.tag),
            .o_rd    (way_rd[g])
        );
    end

    dcache_way_select dcache_way_select_inst (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_rd           (way_rd),
        .i_index        (index),
        .i_lru_touch    (lru_touch),
        .i_lru_way      (lru_way),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_rd_line      (rd_line),
        .o_victim_way   (victim_way),
        .o_victim_tag   (victim_tag),
        .o_victim_flags (victim_flags)
    );

endmodule

`default_nettype wire

/* dcache_trace.txt */
// op addr wdata wstrb expdata kind (op 0 load, 1 store, other ends the trace)
// kind 0 hit, 1 miss, 2 miss with write-back; expdata is checked for loads only
0 00001020 0000000000000000 00 A5A5B585A5A5B585 1
0 00001020 0000000000000000 00 A5A5B585A5A5B585 0
0 00001028 0000000000000000 00 A5A5B58DA5A5B58D 0
1 00001028 1122334455667788 0F 0000000000000000 0
0 00001028 0000000000000000 00 A5A5B58D55667788 0
0 00002020 0000000000000000 00 A5A58585A5A58585 1
0 00003020 0000000000000000 00 A5A59585A5A59585 2
0 00001028 0000000000000000 00 A5A5B58D55667788 1
1 00004058 DEADBEEFCAFEF00D C3 0000000000000000 1
0 00004058 0000000000000000 00 DEADE5FDA5A5F00D 0
0 00004050 0000000000000000 00 A5A5E5F5A5A5E5F5 0
0 00004040 0000000000000000 00 A5A5E5E5A5A5E5E5 0
0 00005050 0000000000000000 00 A5A5F5F5A5A5F5F5 1
0 00006050 0000000000000000 00 A5A5C5F5A5A5C5F5 2
0 00004058 0000000000000000 00 DEADE5FDA5A5F00D 1
1 00004058 0102030405060708 3C 0000000000000000 0
0 00004058 0000000000000000 00 DEAD03040506F00D 0
F

/* dcache_way.sv */
//##########################################################
// Data cache way
// Tag, flag and line storage of one way with tag compare
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_way (
    input  wire logic                       i_clk,
    input  wire logic                       i_nrst,
    input  wire logic [`DC_INDEX_BITS-1:0]  i_index,
    input  wire logic                       i_we,
    input  wire dcache_line_pkg::way_wr_t   i_wr,
    input  wire logic [`DC_TAG_BITS-1:0]    i_tag,
    output dcache_line_pkg::way_rd_t        o_rd
);

    logic [`DC_TAG_BITS-1:0]        tag_mem [`DC_SETS];
    dcache_line_pkg::tag_flags_t    flag_mem [`DC_SETS];
    logic [`DC_LINE_BYTES*8-1:0]    data_mem [`DC_SETS];

    logic [`DC_TAG_BITS-1:0]        tag_q;
    dcache_line_pkg::tag_flags_t    flags_q;
    logic [`DC_LINE_BYTES*8-1:0]    data_q;

    // Storage write and synchronous read of tag and line
    always_ff @(posedge i_clk) begin
        if (i_we && i_wr.we) begin
            tag_mem[i_wr.index]  <= i_wr.tag;
            flag_mem[i_wr.index] <= i_wr.flags;
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (i_wr.strb[b]) begin
                    data_mem[i_wr.index][b*8 +: 8] <= i_wr.data[b*8 +: 8];
                end
            end
        end
        tag_q  <= tag_mem[i_index];
        data_q <= data_mem[i_index];
    end

    // Flags come out invalid until the first read after reset
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            flags_q <= '0;
        end else begin
            flags_q <= flag_mem[i_index];
        end
    end

    always_comb begin
        o_rd.hit   = flags_q.valid && (tag_q == i_tag);
        o_rd.tag   = tag_q;
        o_rd.flags = flags_q;
        o_rd.data  = data_q;
    end

endmodule

`default_nettype wire

/* dcache_way_select.sv */
//##########################################################
// Data cache way select
// Hit merge, line mux, victim choice and per-set LRU bits
//##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_way_select (
    input  wire logic                                       i_clk,
    input  wire logic                                       i_nrst,
    input  wire dcache_line_pkg::way_rd_t [`DC_WAYS-1:0]    i_rd,
    input  wire logic [`DC_INDEX_BITS-1:0]                  i_index,
    input  wire logic                                       i_lru_touch,
    input  wire logic [$clog2(`DC_WAYS)-1:0]                i_lru_way,
    output logic                                            o_hit,
    output logic [$clog2(`DC_WAYS)-1:0]                     o_hit_way,
    output logic [`DC_LINE_BYTES*8-1:0]                     o_rd_line,
    output logic [$clog2(`DC_WAYS)-1:0]                     o_victim_way,
    output logic [`DC_TAG_BITS-1:0]                         o_victim_tag,
    output dcache_line_pkg::tag_flags_t                     o_victim_flags
);

    localparam int WAY_BITS = $clog2(`DC_WAYS);

    // Per set, the way used least recently
    logic [`DC_SETS-1:0] lru_q;
    logic                found_invalid;

    always_comb begin
        o_hit         = 1'b0;
        o_hit_way     = '0;
        found_invalid = 1'b0;
        o_victim_way  = lru_q[i_index];
        for (int w = 0; w < `DC_WAYS; w++) begin
            o_hit = o_hit | i_rd[w].hit;
            if (i_rd[w].hit) begin
                o_hit_way = WAY_BITS'(w);
            end
            // An empty way wins over the LRU choice
            if (!i_rd[w].flags.valid && !found_invalid) begin
                found_invalid = 1'b1;
                o_victim_way  = WAY_BITS'(w);
            end
        end
        o_victim_tag   = i_rd[o_victim_way].tag;
        o_victim_flags = i_rd[o_victim_way].flags;
        // On a miss the victim line goes out for write-back
        o_rd_line = o_hit ? i_rd[o_hit_way].data : i_rd[o_victim_way].data;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            lru_q <= '0;
        end else if (i_lru_touch) begin
            lru_q[i_index] <= ~i_lru_way;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
dcache_bus_pkg.sv
dcache_line_pkg.sv
dcache_way.sv
dcache_way_select.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

/* tb_dcache.sv */
//############################################################
// Data cache testbench
// Trace replay against a line memory model with random delays
//############################################################
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache;

    localparam int MAX_ACCESSES = 64;
    localparam int FIELDS       = 6;
    localparam int LINE_BITS    = `DC_LINE_BYTES * 8;
    localparam int LINE_WORDS   = `DC_LINE_BYTES / 8;

    logic                           i_clk;
    logic                           i_nrst;
    logic                           i_req_valid;
    dcache_bus_pkg::cpu_req_t       i_req;
    logic                           o_req_ready;
    logic                           o_resp_valid;
    dcache_bus_pkg::cpu_resp_t      o_resp;
    logic                           i_resp_ready;
    logic                           o_mem_valid;
    dcache_bus_pkg::mem_req_t       o_mem_req;
    logic                           i_mem_ready;
    logic                           i_mem_data_valid;
    logic [LINE_BITS-1:0]           i_mem_data;

    // Trace records of FIELDS words each
    logic [63:0]                    trace_words [FIELDS*MAX_ACCESSES];
    int                             num_accesses;
    int                             cycle_cnt = 0;
    int                             cycle_limit;

    // Memory model state shared with the replay loop
    logic [63:0]                    mem_words [logic [31:0]];
    logic [31:0]                    cur_line_addr;
    int                             mem_reads = 0;
    int                             mem_writes = 0;

    dcache_top dcache_top_inst (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_req_valid      (i_req_valid),
        .i_req            (i_req),
        .o_req_ready      (o_req_ready),
        .o_resp_valid     (o_resp_valid),
        .o_resp           (o_resp),
        .i_resp_ready     (i_resp_ready),
        .o_mem_valid      (o_mem_valid),
        .o_mem_req        (o_mem_req),
        .i_mem_ready      (i_mem_ready),
        .i_mem_data_valid (i_mem_data_valid),
        .i_mem_data       (i_mem_data)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Unwritten words hold their own address XOR a fixed pattern
    function automatic logic [63:0] mem_word(input logic [31:0] addr);
        logic [31:0] pat;
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        pat = addr ^ 32'hA5A5A5A5;
        return {pat, pat};
    endfunction

    initial begin : clock_gen
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            stop_on_error($sformatf("Timeout after %0d cycles without finishing the trace",
                                    cycle_limit));
        end
    end

    // Line memory serving one transfer at a time with random grant and data delays
    initial begin : memory_model
        dcache_bus_pkg::mem_req_t req;
        i_mem_ready      = 1'b0;
        i_mem_data_valid = 1'b0;
        i_mem_data       = '0;
        forever begin
            @(negedge i_clk);
            if (o_mem_valid) begin
                req = o_mem_req;
                assert (req.addr[`DC_LINE_OFFS_BITS-1:0] == '0) else
                    stop_on_error($sformatf("CHECK FAILED o_mem_req.addr offset got %h expected %h",
                                            req.addr[`DC_LINE_OFFS_BITS-1:0],
                                            `DC_LINE_OFFS_BITS'(0)));
                repeat ($urandom % 4) @(negedge i_clk);
                i_mem_ready = 1'b1;
                @(negedge i_clk);
                i_mem_ready = 1'b0;
                repeat ($urandom % 4) @(negedge i_clk);
                if (req.write) begin
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        mem_words[req.addr + 32'(w * 8)] = req.data[w*64 +: 64];
                    end
                    mem_writes++;
                end else begin
                    assert (req.addr == cur_line_addr) else
                        stop_on_error($sformatf("CHECK FAILED o_mem_req.addr got %h expected %h",
                                                req.addr, cur_line_addr));
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        i_mem_data[w*64 +: 64] = mem_word(req.addr + 32'(w * 8));
                    end
                    mem_reads++;
                end
                i_mem_data_valid = 1'b1;
                @(negedge i_clk);
                i_mem_data_valid = 1'b0;
            end
        end
    end

    // Kind 0 is a hit, 1 a miss, 2 a miss with write-back
    task automatic replay_access(input int n);
        dcache_bus_pkg::cpu_req_t   req;
        dcache_bus_pkg::cpu_resp_t  first_resp;
        logic [63:0]                exp_data;
        logic [1:0]                 kind;
        int                         reads_before;
        int                         writes_before;
        int                         exp_reads;
        int                         exp_writes;
        int                         resp_wait;
        int                         hold;
        int                         held;
        bit                         seen;
        bit                         done;
        req.op        = dcache_bus_pkg::mem_op_t'(trace_words[n*FIELDS][0]);
        req.addr      = trace_words[n*FIELDS+1][`DC_ADDR_BITS-1:0];
        req.wdata     = trace_words[n*FIELDS+2];
        req.wstrb     = trace_words[n*FIELDS+3][`DC_STRB_BITS-1:0];
        exp_data      = trace_words[n*FIELDS+4];
        kind          = trace_words[n*FIELDS+5][1:0];
        cur_line_addr = req.addr & ~32'(`DC_LINE_BYTES - 1);
        reads_before  = mem_reads;
        writes_before = mem_writes;
        exp_reads     = (kind != 2'd0) ? 1 : 0;
        exp_writes    = (kind == 2'd2) ? 1 : 0;
        hold          = int'($urandom % 4);

        i_req       = req;
        i_req_valid = 1'b1;
        while (!o_req_ready) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);
        i_req_valid = 1'b0;

        seen      = 1'b0;
        done      = 1'b0;
        held      = 0;
        resp_wait = 0;
        while (!done) begin
            if (kind == 2'd0) begin
                assert (!o_mem_valid) else
                    stop_on_error("A hit raised a memory request");
                if (resp_wait == 0) begin
                    assert (o_resp_valid) else
                        stop_on_error("A hit did not respond one cycle after acceptance");
                end
            end
            if (o_resp_valid && !seen) begin
                seen       = 1'b1;
                first_resp = o_resp;
                assert (o_resp.addr == req.addr) else
                    stop_on_error($sformatf("CHECK FAILED o_resp.addr got %h expected %h",
                                            o_resp.addr, req.addr));
                if (req.op == dcache_bus_pkg::MEM_OP_LOAD) begin
                    assert (o_resp.rdata == exp_data) else
                        stop_on_error($sformatf("CHECK FAILED o_resp.rdata got %h expected %h",
                                                o_resp.rdata, exp_data));
                end
            end else if (seen) begin
                assert (o_resp_valid) else
                    stop_on_error("o_resp_valid dropped before i_resp_ready was seen");
                assert (o_resp == first_resp) else
                    stop_on_error($sformatf("CHECK FAILED o_resp got %h expected %h",
                                            o_resp, first_resp));
            end
            // Ready held low for a few cycles once the response shows
            i_resp_ready = seen && (held >= hold);
            if (seen) begin
                held++;
            end
            done = o_resp_valid && i_resp_ready;
            resp_wait++;
            @(negedge i_clk);
        end
        i_resp_ready = 1'b0;

        assert (mem_reads - reads_before == exp_reads) else
            stop_on_error($sformatf("CHECK FAILED mem_reads got %h expected %h for access %0d",
                                    mem_reads - reads_before, exp_reads, n));
        assert (mem_writes - writes_before == exp_writes) else
            stop_on_error($sformatf("CHECK FAILED mem_writes got %h expected %h for access %0d",
                                    mem_writes - writes_before, exp_writes, n));
    endtask

    initial begin : replay
        int wait_cycles;
        void'($urandom(32'h480b));
        i_nrst       = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_resp_ready = 1'b0;

        for (int i = 0; i < FIELDS * MAX_ACCESSES; i++) begin
            trace_words[i] = '1;
        end
        $readmemh("dcache_trace.txt", trace_words);
        num_accesses = 0;
        while (num_accesses < MAX_ACCESSES && trace_words[num_accesses*FIELDS] <= 64'd1) begin
            num_accesses++;
        end
        cycle_limit = num_accesses * 40 + `DC_SETS + 3;
        if (num_accesses == 0) begin
            stop_on_error("The trace file holds no accesses");
        end

        repeat (3) begin
            @(negedge i_clk);
            assert (!o_req_ready && !o_resp_valid && !o_mem_valid) else
                stop_on_error("Control outputs were not low during reset");
        end
        i_nrst = 1'b1;

        // Nothing may leave the cache during the invalidation sweep
        wait_cycles = 0;
        while (!o_req_ready) begin
            assert (!o_mem_valid && !o_resp_valid) else
                stop_on_error("A control output rose during the reset sweep");
            wait_cycles++;
            assert (wait_cycles <= `DC_SETS + 4) else
                stop_on_error("o_req_ready did not rise after the reset sweep");
            @(negedge i_clk);
        end

        for (int n = 0; n < num_accesses; n++) begin
            replay_access(n);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
